/* design/axis_stream_pkg.sv */
// ------------------
// Stream geometry for the narrow input side and the wide output side.
// ------------------
`default_nettype none

package axis_stream_pkg;

    // Bytes carried by one narrow beat.
    localparam int NARROW_BYTES = 1;

    // Narrow beats packed into one wide word.
    localparam int UPSIZE = 4;

    localparam int WIDE_BYTES = NARROW_BYTES * UPSIZE; // Bytes per wide word.

    localparam int TUSER_BITS = 1; // User bits per narrow beat.

    // Width of the lane counter in the upsizer.
    localparam int LANE_INDEX_BITS = (UPSIZE >= 2) ? $clog2(UPSIZE) : 1;

endpackage

`default_nettype wire

/* design/stats_regs_pkg.sv */
// ------------------
// AXI4-Lite widths, register map and response codes
// of the statistics block.
// ------------------
`default_nettype none

package stats_regs_pkg;

    localparam int AXIL_ADDR_BITS = 4;
    localparam int AXIL_DATA_BITS = 32;

    // Byte offsets of the registers.
    localparam logic [AXIL_ADDR_BITS-1:0] REG_WORDS   = 4'h0; // Wide words sent.
    localparam logic [AXIL_ADDR_BITS-1:0] REG_PACKETS = 4'h4; // Words with tlast.
    localparam logic [AXIL_ADDR_BITS-1:0] REG_BYTES   = 4'h8; // Kept bytes.
    localparam logic [AXIL_ADDR_BITS-1:0] REG_CLEAR   = 4'hc; // Clear command.

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* design/axis_if.sv */
// ------------------
// AXI4-Stream interface with a lane count parameter.
// ------------------
`timescale 1ns/100ps
`default_nettype none

interface axis_if #(
    parameter int LANES = 1
);
    import axis_stream_pkg::*;

    logic tvalid;
    logic tready;
    logic [LANES-1:0][NARROW_BYTES*8-1:0] tdata; // Lane 0 is the low byte.
    logic [LANES-1:0][NARROW_BYTES-1:0]   tkeep;
    logic [LANES-1:0][TUSER_BITS-1:0]     tuser;
    logic tlast;

    modport source (
        output tvalid,
        input  tready,
        output tdata,
        output tkeep,
        output tuser,
        output tlast
    );

    modport sink (
        input  tvalid,
        output tready,
        input  tdata,
        input  tkeep,
        input  tuser,
        input  tlast
    );

    // Passive view for observers.
    modport monitor (
        input tvalid,
        input tready,
        input tdata,
        input tkeep,
        input tuser,
        input tlast
    );

endinterface

`default_nettype wire

/* design/axis_skid_buffer.sv */
// ------------------
// Two-entry skid buffer on the narrow input.
// ------------------
`timescale 1ns/100ps
`default_nettype none

module axis_skid_buffer (
    input  logic aclk,
    input  logic areset_n,
    input  logic s_tvalid,
    output logic s_tready,
    input  logic [axis_stream_pkg::NARROW_BYTES*8-1:0] s_tdata,
    input  logic [axis_stream_pkg::NARROW_BYTES-1:0]   s_tkeep,
    input  logic [axis_stream_pkg::TUSER_BITS-1:0]     s_tuser,
    input  logic s_tlast,
    axis_if.source tx
);
    import axis_stream_pkg::*;

    logic skid_valid;
    logic [NARROW_BYTES*8-1:0] skid_data;
    logic [NARROW_BYTES-1:0]   skid_keep;
    logic [TUSER_BITS-1:0]     skid_user;
    logic skid_last;

    logic s_hs;
    logic out_free;

    assign s_hs     = s_tvalid && s_tready;
    assign out_free = !tx.tvalid || tx.tready; // Main entry can be reloaded.

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx.tvalid  <= 1'b0;
            skid_valid <= 1'b0;
            s_tready   <= 1'b0;
        end else if (out_free) begin
            tx.tvalid  <= skid_valid || s_hs;
            skid_valid <= 1'b0;
            s_tready   <= 1'b1;
        end else if (s_hs) begin
            // Main entry stalled, beat parks in the skid entry.
            skid_valid <= 1'b1;
            s_tready   <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (out_free) begin
            if (skid_valid) begin
                tx.tdata <= skid_data;
                tx.tkeep <= skid_keep;
                tx.tuser <= skid_user;
                tx.tlast <= skid_last;
            end else begin
                tx.tdata <= s_tdata;
                tx.tkeep <= s_tkeep;
                tx.tuser <= s_tuser;
                tx.tlast <= s_tlast;
            end
        end
        if (!out_free && s_hs) begin
            skid_data <= s_tdata;
            skid_keep <= s_tkeep;
            skid_user <= s_tuser;
            skid_last <= s_tlast;
        end
    end

endmodule

`default_nettype wire

/* design/axis_upsizer_unit.sv */
// ------------------
// Packs narrow beats into wide words of UPSIZE lanes.
// A tlast beat closes the word early.
// ------------------
`timescale 1ns/100ps
`default_nettype none

module axis_upsizer_unit (
    input logic aclk,
    input logic areset_n,
    axis_if.sink   rx,
    axis_if.source tx
);
    import axis_stream_pkg::*;

    enum logic [1:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_WORD,
        ST_LAST
    } state;

    logic [LANE_INDEX_BITS-1:0] lane_idx;
    logic lane_last;
    logic rx_hs;
    logic word_close;
    logic [UPSIZE-1:0] lane_wr;

    logic [UPSIZE-1:0][NARROW_BYTES*8-1:0] buf_data;
    logic [UPSIZE-1:0][NARROW_BYTES-1:0]   buf_keep;
    logic [UPSIZE-1:0][TUSER_BITS-1:0]     buf_user;

    assign lane_last  = (lane_idx == LANE_INDEX_BITS'(UPSIZE - 1));
    assign rx_hs      = rx.tvalid && rx.tready;
    assign word_close = rx.tlast || lane_last; // Beat ends the current word.

    always_comb begin
        case (state)
            ST_IDLE:    rx.tready = 1'b0; // First cycle out of reset.
            ST_COLLECT: rx.tready = 1'b1;
            default:    rx.tready = !rx.tvalid || tx.tready;
        endcase
    end

    always_comb begin
        for (int k = 0; k < UPSIZE; k++) begin
            lane_wr[k] = rx_hs && (lane_idx == LANE_INDEX_BITS'(k));
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            lane_idx <= '0;
        end else if (rx_hs) begin
            lane_idx <= word_close ? '0 : lane_idx + 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    state <= ST_COLLECT;
                end
                ST_COLLECT: begin
                    if (rx_hs && word_close) begin
                        state <= rx.tlast ? ST_LAST : ST_WORD;
                    end
                end
                default: begin
                    // Word leaves the buffer once the output moves.
                    if (tx.tready) begin
                        if (rx_hs && word_close) begin
                            state <= rx.tlast ? ST_LAST : ST_WORD;
                        end else begin
                            state <= ST_COLLECT;
                        end
                    end
                end
            endcase
        end
    end

    // Lane 0 starts a word and zeroes keep and user of the rest.
    always_ff @(posedge aclk) begin
        if (lane_wr[0]) begin
            buf_keep <= '0;
            buf_user <= '0;
        end
        for (int k = 0; k < UPSIZE; k++) begin
            if (lane_wr[k]) begin
                buf_data[k] <= rx.tdata[0];
                buf_keep[k] <= rx.tkeep[0];
                buf_user[k] <= rx.tuser[0];
            end
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            tx.tvalid <= 1'b0;
        end else if (tx.tready) begin
            tx.tvalid <= (state == ST_WORD) || (state == ST_LAST);
        end
    end

    always_ff @(posedge aclk) begin
        if (tx.tready) begin
            tx.tdata <= buf_data;
            tx.tkeep <= buf_keep;
            tx.tuser <= buf_user;
            tx.tlast <= (state == ST_LAST); // Word closed by tlast.
        end
    end

endmodule

`default_nettype wire

/* design/axis_stream_stats.sv */
// ------------------
// Word, packet and byte counters on the wide stream,
// read and cleared over AXI4-Lite.
// ------------------
`timescale 1ns/100ps
`default_nettype none

module axis_stream_stats (
    input  logic aclk,
    input  logic areset_n,
    axis_if.monitor mon,
    input  logic [stats_regs_pkg::AXIL_ADDR_BITS-1:0]   s_axil_awaddr,
    input  logic                                        s_axil_awvalid,
    output logic                                        s_axil_awready,
    input  logic [stats_regs_pkg::AXIL_DATA_BITS-1:0]   s_axil_wdata,
    input  logic [stats_regs_pkg::AXIL_DATA_BITS/8-1:0] s_axil_wstrb,
    input  logic                                        s_axil_wvalid,
    output logic                                        s_axil_wready,
    output logic [1:0]                                  s_axil_bresp,
    output logic                                        s_axil_bvalid,
    input  logic                                        s_axil_bready,
    input  logic [stats_regs_pkg::AXIL_ADDR_BITS-1:0]   s_axil_araddr,
    input  logic                                        s_axil_arvalid,
    output logic                                        s_axil_arready,
    output logic [stats_regs_pkg::AXIL_DATA_BITS-1:0]   s_axil_rdata,
    output logic [1:0]                                  s_axil_rresp,
    output logic                                        s_axil_rvalid,
    input  logic                                        s_axil_rready
);
    import stats_regs_pkg::*;

    logic [AXIL_DATA_BITS-1:0] word_count;
    logic [AXIL_DATA_BITS-1:0] packet_count;
    logic [AXIL_DATA_BITS-1:0] byte_count;
    logic [AXIL_DATA_BITS-1:0] rd_data;
    logic [1:0] rd_resp;

    logic wide_hs;
    logic wr_ready;
    logic wr_hs;
    logic rd_hs;
    logic clear;

    assign wide_hs = mon.tvalid && mon.tready;
    assign s_axil_awready = wr_ready; // Address and data accepted together.
    assign s_axil_wready  = wr_ready;
    assign wr_hs = wr_ready && s_axil_awvalid && s_axil_wvalid;
    assign rd_hs = s_axil_arvalid && s_axil_arready;

    // Bit 0 of an enabled low byte triggers the clear.
    assign clear = wr_hs && (s_axil_awaddr == REG_CLEAR) && s_axil_wstrb[0] && s_axil_wdata[0];

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            word_count   <= '0;
            packet_count <= '0;
            byte_count   <= '0;
        end else if (clear) begin
            word_count   <= '0;
            packet_count <= '0;
            byte_count   <= '0;
        end else if (wide_hs) begin
            word_count <= word_count + 1'b1;
            if (mon.tlast) begin
                packet_count <= packet_count + 1'b1;
            end
            byte_count <= byte_count + AXIL_DATA_BITS'($countones(mon.tkeep));
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ready      <= 1'b0;
            s_axil_bvalid <= 1'b0;
            s_axil_bresp  <= RESP_OKAY;
        end else begin
            wr_ready <= !wr_ready && !s_axil_bvalid && s_axil_awvalid && s_axil_wvalid;
            if (wr_hs) begin
                s_axil_bvalid <= 1'b1;
                s_axil_bresp  <= (s_axil_awaddr == REG_CLEAR) ? RESP_OKAY : RESP_SLVERR;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_resp = RESP_OKAY;
        case (s_axil_araddr)
            REG_WORDS:   rd_data = word_count;
            REG_PACKETS: rd_data = packet_count;
            REG_BYTES:   rd_data = byte_count;
            REG_CLEAR:   rd_data = '0; // Command register reads as zero.
            default: begin
                rd_data = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            s_axil_rresp   <= RESP_OKAY;
        end else begin
            s_axil_arready <= !s_axil_arready && !s_axil_rvalid && s_axil_arvalid;
            if (rd_hs) begin
                s_axil_rvalid <= 1'b1;
                s_axil_rresp  <= rd_resp;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_hs) begin
            s_axil_rdata <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* design/axis_upsizer_top.sv */
// ------------------
// Upsizer top level with skid buffer, packing unit
// and statistics registers.
// ------------------
`timescale 1ns/100ps
`default_nettype none

module axis_upsizer_top (
    input  logic aclk,
    input  logic areset_n,
    input  logic s_tvalid,
    output logic s_tready,
    input  logic [axis_stream_pkg::NARROW_BYTES*8-1:0] s_tdata,
    input  logic [axis_stream_pkg::NARROW_BYTES-1:0]   s_tkeep,
    input  logic [axis_stream_pkg::TUSER_BITS-1:0]     s_tuser,
    input  logic s_tlast,
    output logic m_tvalid,
    input  logic m_tready,
    output logic [axis_stream_pkg::WIDE_BYTES*8-1:0] m_tdata,
    output logic [axis_stream_pkg::WIDE_BYTES-1:0]   m_tkeep,
    output logic [axis_stream_pkg::UPSIZE*axis_stream_pkg::TUSER_BITS-1:0] m_tuser,
    output logic m_tlast,
    input  logic [stats_regs_pkg::AXIL_ADDR_BITS-1:0]   s_axil_awaddr,
    input  logic                                        s_axil_awvalid,
    output logic                                        s_axil_awready,
    input  logic [stats_regs_pkg::AXIL_DATA_BITS-1:0]   s_axil_wdata,
    input  logic [stats_regs_pkg::AXIL_DATA_BITS/8-1:0] s_axil_wstrb,
    input  logic                                        s_axil_wvalid,
    output logic                                        s_axil_wready,
    output logic [1:0]                                  s_axil_bresp,
    output logic                                        s_axil_bvalid,
    input  logic                                        s_axil_bready,
    input  logic [stats_regs_pkg::AXIL_ADDR_BITS-1:0]   s_axil_araddr,
    input  logic                                        s_axil_arvalid,
    output logic                                        s_axil_arready,
    output logic [stats_regs_pkg::AXIL_DATA_BITS-1:0]   s_axil_rdata,
    output logic [1:0]                                  s_axil_rresp,
    output logic                                        s_axil_rvalid,
    input  logic                                        s_axil_rready
);
    import axis_stream_pkg::*;

    axis_if #(.LANES(1))      narrow_in ();
    axis_if #(.LANES(UPSIZE)) wide_out ();

    assign m_tvalid = wide_out.tvalid;
    assign wide_out.tready = m_tready;
    assign m_tdata  = wide_out.tdata;
    assign m_tkeep  = wide_out.tkeep;
    assign m_tuser  = wide_out.tuser;
    assign m_tlast  = wide_out.tlast;

    axis_skid_buffer u_skid (
        .aclk     (aclk),
        .areset_n (areset_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tuser  (s_tuser),
        .s_tlast  (s_tlast),
        .tx       (narrow_in.source)
    );

    axis_upsizer_unit u_unit (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx       (narrow_in.sink),
        .tx       (wide_out.source)
    );

    axis_stream_stats u_stats (
        .aclk           (aclk),
        .areset_n       (areset_n),
        .mon            (wide_out.monitor),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready)
    );

endmodule

`default_nettype wire

/* sim/axis_upsizer_checker.sv */
// --------------------
// Bound assertions on stall stability, reset state
// and AXI4-Lite response codes.
// --------------------
`timescale 1ns/100ps
`default_nettype none

module axis_upsizer_checker (
    input logic aclk,
    input logic areset_n,
    input logic s_tready,
    input logic m_tvalid,
    input logic m_tready,
    input logic [axis_stream_pkg::WIDE_BYTES*8-1:0] m_tdata,
    input logic [axis_stream_pkg::WIDE_BYTES-1:0]   m_tkeep,
    input logic [axis_stream_pkg::UPSIZE*axis_stream_pkg::TUSER_BITS-1:0] m_tuser,
    input logic m_tlast,
    input logic s_axil_awready,
    input logic s_axil_wready,
    input logic s_axil_arready,
    input logic [1:0] s_axil_bresp,
    input logic s_axil_bvalid,
    input logic [1:0] s_axil_rresp,
    input logic s_axil_rvalid
);
    import stats_regs_pkg::*;

    logic stall_err   = 1'b0;
    logic reset_err   = 1'b0;
    logic release_err = 1'b0;
    logic bresp_err   = 1'b0;
    logic rresp_err   = 1'b0;
    logic failed;

    assign failed = stall_err || reset_err || release_err || bresp_err || rresp_err;

    // A stalled wide word holds until it transfers.
    assert property (@(posedge aclk) disable iff (!areset_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep)
            && $stable(m_tuser) && $stable(m_tlast))
        else begin
            $error("wide word changed while stalled");
            stall_err = 1'b1;
        end

    assert property (@(posedge aclk)
        !areset_n |=> !s_tready && !m_tvalid && !s_axil_bvalid && !s_axil_rvalid
            && !s_axil_awready && !s_axil_wready && !s_axil_arready)
        else begin
            $error("handshake output high in or right after reset");
            reset_err = 1'b1;
        end

    assert property (@(posedge aclk)
        $rose(areset_n) |=> !m_tvalid && !s_axil_bvalid && !s_axil_rvalid)
        else begin
            $error("valid output high in the first cycle after reset");
            release_err = 1'b1;
        end

    assert property (@(posedge aclk) disable iff (!areset_n)
        s_axil_bvalid |-> (s_axil_bresp == RESP_OKAY || s_axil_bresp == RESP_SLVERR))
        else begin
            $error("write response code is neither OKAY nor SLVERR");
            bresp_err = 1'b1;
        end

    assert property (@(posedge aclk) disable iff (!areset_n)
        s_axil_rvalid |-> (s_axil_rresp == RESP_OKAY || s_axil_rresp == RESP_SLVERR))
        else begin
            $error("read response code is neither OKAY nor SLVERR");
            rresp_err = 1'b1;
        end

endmodule

bind axis_upsizer_top axis_upsizer_checker u_checker (
    .aclk           (aclk),
    .areset_n       (areset_n),
    .s_tready       (s_tready),
    .m_tvalid       (m_tvalid),
    .m_tready       (m_tready),
    .m_tdata        (m_tdata),
    .m_tkeep        (m_tkeep),
    .m_tuser        (m_tuser),
    .m_tlast        (m_tlast),
    .s_axil_awready (s_axil_awready),
    .s_axil_wready  (s_axil_wready),
    .s_axil_arready (s_axil_arready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid)
);

`default_nettype wire

/* sim/tb_axis_upsizer.sv */
// --------------------
// Testbench for the AXI4-Stream upsizer with random packets,
// a lane packing scoreboard and statistics register accesses.
// --------------------
`timescale 1ns/100ps
`default_nettype none

module tb_axis_upsizer;
    import axis_stream_pkg::*;
    import stats_regs_pkg::*;

    typedef struct packed {
        logic                           last;
        logic [UPSIZE*TUSER_BITS-1:0]   user;
        logic [WIDE_BYTES-1:0]          keep;
        logic [WIDE_BYTES*8-1:0]        data;
    } word_t;

    logic aclk = 1'b0;
    logic areset_n;
    logic s_tvalid;
    logic s_tready;
    logic [NARROW_BYTES*8-1:0] s_tdata;
    logic [NARROW_BYTES-1:0]   s_tkeep;
    logic [TUSER_BITS-1:0]     s_tuser;
    logic s_tlast;
    logic m_tvalid;
    logic m_tready;
    logic [WIDE_BYTES*8-1:0]        m_tdata;
    logic [WIDE_BYTES-1:0]          m_tkeep;
    logic [UPSIZE*TUSER_BITS-1:0]   m_tuser;
    logic m_tlast;
    logic [AXIL_ADDR_BITS-1:0]   s_axil_awaddr;
    logic                        s_axil_awvalid;
    logic                        s_axil_awready;
    logic [AXIL_DATA_BITS-1:0]   s_axil_wdata;
    logic [AXIL_DATA_BITS/8-1:0] s_axil_wstrb;
    logic                        s_axil_wvalid;
    logic                        s_axil_wready;
    logic [1:0]                  s_axil_bresp;
    logic                        s_axil_bvalid;
    logic                        s_axil_bready;
    logic [AXIL_ADDR_BITS-1:0]   s_axil_araddr;
    logic                        s_axil_arvalid;
    logic                        s_axil_arready;
    logic [AXIL_DATA_BITS-1:0]   s_axil_rdata;
    logic [1:0]                  s_axil_rresp;
    logic                        s_axil_rvalid;
    logic                        s_axil_rready;

    int    seed;
    logic  stall_mode;           // Random m_tready when set.
    word_t exp_q[$];             // Expected wide words in order.
    word_t acc;
    word_t exp_w;
    int    acc_lane = 0;
    int    seen_words = 0;
    int    seen_packets = 0;
    int    seen_bytes = 0;
    int    base_words;           // Counts at the last clear.
    int    base_packets;
    int    base_bytes;

    axis_upsizer_top uut (.*);

    always #10 aclk = ~aclk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped after an error");
    endtask

    function automatic logic [WIDE_BYTES*8-1:0] byte_mask(input logic [WIDE_BYTES-1:0] keep);
        logic [WIDE_BYTES*8-1:0] mask;
        mask = '0;
        for (int b = 0; b < WIDE_BYTES; b++) begin
            if (keep[b]) begin
                mask[b*8 +: 8] = 8'hff;
            end
        end
        return mask;
    endfunction

    // Scoreboard. Input beats are packed by lane, output words are popped and compared.
    always @(posedge aclk) begin
        if (areset_n && s_tvalid && s_tready) begin
            if (acc_lane == 0) begin
                acc = '0; // New word, unfilled lanes stay zero.
            end
            acc.data[acc_lane*NARROW_BYTES*8 +: NARROW_BYTES*8] = s_tdata;
            acc.keep[acc_lane*NARROW_BYTES +: NARROW_BYTES] = s_tkeep;
            acc.user[acc_lane*TUSER_BITS +: TUSER_BITS] = s_tuser;
            acc.last = s_tlast;
            if (s_tlast || acc_lane == UPSIZE - 1) begin
                exp_q.push_back(acc);
                acc_lane = 0;
            end else begin
                acc_lane++;
            end
        end
        if (areset_n && m_tvalid && m_tready) begin
            assert (exp_q.size() > 0) else abort_run($sformatf(
                "mismatch at %0t: output word with no expected word", $time));
            exp_w = exp_q.pop_front();
            assert (m_tkeep == exp_w.keep) else abort_run($sformatf(
                "mismatch at %0t: tkeep %h, expected %h", $time, m_tkeep, exp_w.keep));
            assert ((m_tdata & byte_mask(exp_w.keep)) == exp_w.data) else abort_run($sformatf(
                "mismatch at %0t: tdata %h, expected %h", $time, m_tdata, exp_w.data));
            assert (m_tuser == exp_w.user) else abort_run($sformatf(
                "mismatch at %0t: tuser %h, expected %h", $time, m_tuser, exp_w.user));
            assert (m_tlast == exp_w.last) else abort_run($sformatf(
                "mismatch at %0t: tlast %b, expected %b", $time, m_tlast, exp_w.last));
            seen_words++;
            if (exp_w.last) begin
                seen_packets++;
            end
            seen_bytes += $countones(exp_w.keep);
        end
        if (uut.u_checker.failed) begin
            abort_run("a concurrent assertion in the checker failed");
        end
    end

    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge aclk);
        if (stall_mode) begin
            rnd = $random(seed);
            m_tready = (rnd[1:0] != 2'b00); // Ready about three cycles in four.
        end
    endtask

    task automatic send_packet(input int len);
        logic [31:0] rnd;
        int wait_cycles;
        for (int i = 0; i < len; i++) begin
            rnd = $random(seed);
            s_tvalid = 1'b1;
            s_tdata  = rnd[NARROW_BYTES*8-1:0];
            s_tkeep  = '1;
            s_tuser  = rnd[8 +: TUSER_BITS];
            s_tlast  = (i == len - 1);
            wait_cycles = 0;
            while (!s_tready) begin
                next_cycle();
                wait_cycles++;
                if (wait_cycles > 200) begin
                    abort_run("timeout: an input beat was never accepted");
                end
            end
            next_cycle();
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    task automatic run_packets(input int count);
        logic [31:0] rnd;
        for (int p = 0; p < count; p++) begin
            rnd = $random(seed);
            send_packet(int'(rnd % 11) + 1); // 1 to 11 beats.
            if (rnd[20]) begin
                next_cycle();
            end
        end
    endtask

    task automatic wait_drained();
        int wait_cycles;
        wait_cycles = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
            wait_cycles++;
            if (wait_cycles > 2000) begin
                abort_run("timeout: expected output words never arrived");
            end
        end
        repeat (2) next_cycle();
    endtask

    task automatic read_register(input logic [AXIL_ADDR_BITS-1:0] addr,
                                 output logic [AXIL_DATA_BITS-1:0] data,
                                 output logic [1:0] resp);
        int wait_cycles;
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        wait_cycles = 0;
        while (!s_axil_arready) begin
            next_cycle();
            wait_cycles++;
            if (wait_cycles > 20) begin
                abort_run("timeout: read address was never accepted");
            end
        end
        next_cycle();
        s_axil_arvalid = 1'b0;
        wait_cycles = 0;
        while (!s_axil_rvalid) begin
            next_cycle();
            wait_cycles++;
            if (wait_cycles > 20) begin
                abort_run("timeout: read data never arrived");
            end
        end
        data = s_axil_rdata;
        resp = s_axil_rresp;
        next_cycle();
        s_axil_rready = 1'b0;
    endtask

    task automatic expect_write(input logic [AXIL_ADDR_BITS-1:0] addr,
                                input logic [AXIL_DATA_BITS-1:0] data,
                                input logic [1:0] exp_resp,
                                input string what);
        int wait_cycles;
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = '1;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b1;
        wait_cycles = 0;
        while (!s_axil_awready || !s_axil_wready) begin
            next_cycle();
            wait_cycles++;
            if (wait_cycles > 20) begin
                abort_run("timeout: write address or data was never accepted");
            end
        end
        next_cycle();
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        wait_cycles = 0;
        while (!s_axil_bvalid) begin
            next_cycle();
            wait_cycles++;
            if (wait_cycles > 20) begin
                abort_run("timeout: write response never arrived");
            end
        end
        assert (s_axil_bresp == exp_resp) else abort_run($sformatf(
            "mismatch at %0t: %s response %b, expected %b", $time, what, s_axil_bresp, exp_resp));
        next_cycle();
        s_axil_bready = 1'b0;
    endtask

    task automatic expect_register(input logic [AXIL_ADDR_BITS-1:0] addr, input int expected,
                                   input logic [1:0] exp_resp, input string what);
        logic [AXIL_DATA_BITS-1:0] data;
        logic [1:0] resp;
        read_register(addr, data, resp);
        assert (resp == exp_resp) else abort_run($sformatf(
            "mismatch at %0t: %s response %b, expected %b", $time, what, resp, exp_resp));
        assert (data == AXIL_DATA_BITS'(expected)) else abort_run($sformatf(
            "mismatch at %0t: %s read %0d, expected %0d", $time, what, data, expected));
    endtask

    task automatic check_counters();
        expect_register(REG_WORDS, seen_words - base_words, RESP_OKAY, "word count");
        expect_register(REG_PACKETS, seen_packets - base_packets, RESP_OKAY, "packet count");
        expect_register(REG_BYTES, seen_bytes - base_bytes, RESP_OKAY, "byte count");
    endtask

    initial begin
        seed           = 32'h4930_7e0b;
        stall_mode     = 1'b0;
        base_words     = 0;
        base_packets   = 0;
        base_bytes     = 0;
        areset_n       = 1'b0;
        s_tvalid       = 1'b0;
        s_tdata        = '0;
        s_tkeep        = '0;
        s_tuser        = '0;
        s_tlast        = 1'b0;
        m_tready       = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        areset_n = 1'b1;
        repeat (3) next_cycle();

        run_packets(20);         // Output always ready.
        wait_drained();
        stall_mode = 1'b1;
        run_packets(30);         // Random back-pressure.
        wait_drained();
        stall_mode = 1'b0;
        m_tready   = 1'b1;
        check_counters();

        // Unmapped and read-only offsets.
        expect_write(4'h2, 32'h1, RESP_SLVERR, "write to unmapped offset");
        expect_write(REG_BYTES, 32'h1, RESP_SLVERR, "write to byte counter");
        expect_register(4'h6, 0, RESP_SLVERR, "read of unmapped offset");
        check_counters();

        expect_write(REG_CLEAR, 32'h1, RESP_OKAY, "counter clear");
        base_words   = seen_words;
        base_packets = seen_packets;
        base_bytes   = seen_bytes;
        check_counters();

        stall_mode = 1'b1;
        run_packets(12);
        wait_drained();
        stall_mode = 1'b0;
        m_tready   = 1'b1;
        check_counters();

        if (uut.u_checker.failed) begin
            abort_run("a concurrent assertion in the checker failed");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
design/axis_stream_pkg.sv
design/stats_regs_pkg.sv
design/axis_if.sv
design/axis_skid_buffer.sv
design/axis_upsizer_unit.sv
design/axis_stream_stats.sv
design/axis_upsizer_top.sv
sim/axis_upsizer_checker.sv
sim/tb_axis_upsizer.sv

/* run_sim.sh */
#!/bin/sh
# Builds the upsizer testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_axis_upsizer -f tb.f -o tb_axis_upsizer

# The run may exit non-zero on failure; the log decides the result.
./obj_dir/tb_axis_upsizer +verilator+error+limit+10 2>&1 | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
